/* common/cramPkg.sv */
package cramPkg;

  localparam int cramWidth = 36;

  // Field widths from the top bit down
  localparam int arSelWidth = 3;
  localparam int arxSelWidth = 3;
  localparam int mqSelWidth = 2;
  localparam int dispWidth = 5;
  localparam int specWidth = 5;
  localparam int adWidth = 6;
  localparam int magicWidth = 9;
  localparam int condWidth = 3;

  typedef struct packed {
    logic [0:arSelWidth-1] arSel;
    logic [0:arxSelWidth-1] arxSel;
    logic [0:mqSelWidth-1] mqSel;
    logic [0:dispWidth-1] disp;
    logic [0:specWidth-1] spec;
    logic [0:adWidth-1] ad;
    logic [0:magicWidth-1] magic;
    logic [0:condWidth-1] cond;
  } microWordT;

  localparam logic [0:arSelWidth-1] arHold = 3'd0;
  localparam logic [0:arSelWidth-1] arMagic = 3'd1;   // Zero-extended magic number
  localparam logic [0:arSelWidth-1] arArx = 3'd2;
  localparam logic [0:arSelWidth-1] arAdd = 3'd3;     // AR + ARX + carry36
  localparam logic [0:arSelWidth-1] arEbus = 3'd4;

  localparam logic [0:arxSelWidth-1] arxHold = 3'd0;
  localparam logic [0:arxSelWidth-1] arxAr = 3'd1;
  localparam logic [0:arxSelWidth-1] arxMq = 3'd2;
  localparam logic [0:arxSelWidth-1] arxMagic = 3'd3;

  localparam logic [0:mqSelWidth-1] mqHold = 2'd0;
  localparam logic [0:mqSelWidth-1] mqAr = 2'd1;
  localparam logic [0:mqSelWidth-1] mqZero = 2'd2;

  // Reduced SPEC set
  localparam logic [0:specWidth-1] specNone = 5'd0;
  localparam logic [0:specWidth-1] specXcryAr0 = 5'd1;
  localparam logic [0:specWidth-1] specClrArl = 5'd2;
  localparam logic [0:specWidth-1] specClrArr = 5'd3;
  localparam logic [0:specWidth-1] specMqShift = 5'd4;

  localparam logic [0:dispWidth-1] dispNicond = 5'd5;

endpackage

/* common/ebusPkg.sv */
package ebusPkg;

  localparam int ebusWidth = 36;

  typedef logic [0:ebusWidth-1] ebusWordT;

  // Diagnostic function codes
  localparam int diagFuncWidth = 3;
  localparam logic [0:diagFuncWidth-1] diagCrmWrite = 3'd0;
  localparam logic [0:diagFuncWidth-1] diagCrmRead = 3'd1;
  localparam logic [0:diagFuncWidth-1] diagArRead = 3'd4;

  // EBUS peers
  localparam int numPeers = 2;
  localparam int peerCrm = 0;
  localparam int peerCtl = 1;

endpackage

/* dv/eboxTb.sv */
`timescale 1ns/1ps

module eboxTb;
  import cramPkg::*;
  import ebusPkg::*;

  localparam int numRows = 10;
  localparam int creditDepth = 4;
  localparam int cycleLimit = numRows * 20;
  localparam logic [2:0] noRead = 3'd7;
  localparam logic [4:0] nicondCode = cramPkg::dispNicond;

  typedef struct packed {
    logic [5:0] addr;
    logic [35:0] word;
    logic [35:0] ebusIn;  // On diagData while the word executes
    logic [2:0] readFunc;
    logic [35:0] arBefore;
    logic [35:0] arxBefore;
    logic [35:0] mqBefore;
    logic [35:0] arAfter;
    logic [35:0] arxAfter;
    logic [35:0] mqAfter;
  } rowT;

  logic eboxClk = 1'b0;
  logic reset;
  logic [5:0] uAddr;
  logic uStep;
  logic diagStrobe;
  logic [2:0] diagFunc;
  logic [5:0] diagAddr;
  logic [35:0] diagData;
  logic ebusValid;
  logic [35:0] ebusData;
  logic ebusCreditReturn;
  logic [35:0] ar;
  logic [35:0] arx;
  logic [35:0] mq;
  logic nicondFlag;

  rowT rows [numRows];
  int rowCount = 0;
  logic [35:0] mAr;  // Reference model state
  logic [35:0] mArx;
  logic [35:0] mMq;
  logic [35:0] crmExp [$];
  logic [35:0] ctlExp [$];
  int checks = 0;
  int errors = 0;
  int gotWords = 0;
  int returned = 0;
  int owed = 0;
  int cycles = 0;
  int stalled;
  logic withhold = 1'b0;
  logic prevNic;
  logic matchCrm;
  logic matchCtl;

  ebox #(.crmDepth(64), .ebusCredits(creditDepth)) u_dut (
    .eboxClk(eboxClk), .reset(reset), .uAddr(uAddr), .uStep(uStep),
    .diagStrobe(diagStrobe), .diagFunc(diagFunc), .diagAddr(diagAddr), .diagData(diagData),
    .ebusValid(ebusValid), .ebusData(ebusData), .ebusCreditReturn(ebusCreditReturn),
    .ar(ar), .arx(arx), .mq(mq), .dispNicond(nicondFlag)
  );

  always #4 eboxClk = ~eboxClk;

  always @(posedge eboxClk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: run did not complete within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  // One executed microword; AR bit 0 is the MSB here
  task automatic applyModel(input logic [35:0] w, input logic [35:0] ebusIn);
    logic [4:0] spec;
    logic [35:0] magic36;
    logic [35:0] nAr;
    logic [35:0] nArx;
    logic [35:0] nMq;
    logic c36;
    spec = w[22:18];
    magic36 = {27'b0, w[11:3]};
    c36 = (mAr[35] && spec == specXcryAr0) ^ w[17];
    case (w[35:33])
      arMagic: nAr = magic36;
      arArx: nAr = mArx;
      arAdd: nAr = mAr + mArx + c36;
      arEbus: nAr = ebusIn;
      default: nAr = mAr;
    endcase
    if (spec == specClrArl) nAr[35:18] = '0;
    if (spec == specClrArr) nAr[17:0] = '0;
    case (w[32:30])
      arxAr: nArx = mAr;
      arxMq: nArx = mMq;
      arxMagic: nArx = magic36;
      default: nArx = mArx;
    endcase
    if (spec == specMqShift) nMq = {mMq[34:0], mAr[35]};
    else if (w[29:28] == mqAr) nMq = mAr;
    else if (w[29:28] == mqZero) nMq = '0;
    else nMq = mMq;
    mAr = nAr;
    mArx = nArx;
    mMq = nMq;
  endtask

  task automatic addRow(input logic [5:0] addr, input logic [2:0] arS, input logic [2:0] arxS,
                        input logic [1:0] mqS, input logic [4:0] disp, input logic [4:0] spec,
                        input logic [5:0] ad, input logic [8:0] magic,
                        input logic [35:0] ebusIn, input logic [2:0] func);
    rowT r;
    r.addr = addr;
    r.word = {arS, arxS, mqS, disp, spec, ad, magic, 3'b000};
    r.ebusIn = ebusIn;
    r.readFunc = func;
    r.arBefore = mAr;
    r.arxBefore = mArx;
    r.mqBefore = mMq;
    applyModel(r.word, ebusIn);
    r.arAfter = mAr;
    r.arxAfter = mArx;
    r.mqAfter = mMq;
    rows[rowCount] = r;
    rowCount++;
  endtask

  task automatic checkState(input string what, input logic [35:0] eAr, input logic [35:0] eArx,
                            input logic [35:0] eMq, input logic eNic);
    checks++;
    assert (ar === eAr && arx === eArx && mq === eMq && nicondFlag === eNic) else begin
      errors++;
      $display("FAIL @%0t: %s AR=%h ARX=%h MQ=%h NICOND=%b, expected %h %h %h %b",
               $time, what, ar, arx, mq, nicondFlag, eAr, eArx, eMq, eNic);
    end
  endtask

  // Drives one strobe edge; the caller drops the strobe
  task automatic issueRead(input logic [2:0] func, input logic [5:0] addr,
                           input logic [35:0] expWord);
    @(posedge eboxClk);
    diagStrobe <= 1'b1;
    diagFunc <= func;
    diagAddr <= addr;
    if (func == diagArRead)
      ctlExp.push_back(expWord);
    else
      crmExp.push_back(expWord);
  endtask

  task automatic waitDrained();
    @(posedge eboxClk);
    while (crmExp.size() != 0 || ctlExp.size() != 0)
      @(posedge eboxClk);
  endtask

  // EBUS consumer side
  always @(negedge eboxClk) begin
    if (!reset) begin
      if (ebusCreditReturn)
        returned++;
      if (ebusValid) begin
        gotWords++;
        owed++;
        matchCrm = crmExp.size() != 0 && ebusData === crmExp[0];
        matchCtl = !matchCrm && ctlExp.size() != 0 && ebusData === ctlExp[0];
        checks += 2;
        assert (matchCrm || matchCtl) else begin
          errors++;
          $display("FAIL @%0t: unexpected EBUS word %h", $time, ebusData);
        end
        if (matchCrm)
          void'(crmExp.pop_front());
        if (matchCtl)
          void'(ctlExp.pop_front());
        assert (gotWords - returned <= creditDepth) else begin
          errors++;
          $display("FAIL @%0t: %0d words outstanding", $time, gotWords - returned);
        end
      end
    end
  end

  initial begin : creditReturner
    int delay;
    void'($urandom(56));
    ebusCreditReturn = 1'b0;
    forever begin
      @(posedge eboxClk);
      ebusCreditReturn <= 1'b0;
      if (owed > 0 && !withhold) begin
        delay = $urandom % 6;
        repeat (delay) @(posedge eboxClk);
        ebusCreditReturn <= 1'b1;
        owed--;
      end
    end
  end

  initial begin
    reset = 1'b1;
    uAddr = '0;
    uStep = 1'b0;
    diagStrobe = 1'b0;
    diagFunc = '0;
    diagAddr = '0;
    diagData = '0;
    mAr = '0;
    mArx = '0;
    mMq = '0;
    prevNic = 1'b0;
    addRow(6'd1, arMagic, arxHold, mqHold, 5'd0, specNone, 6'd0, 9'h1A5, '0, diagCrmRead);
    addRow(6'd2, arHold, arxAr, mqHold, nicondCode, specNone, 6'd0, 9'h0, '0, diagArRead);
    addRow(6'd3, arEbus, arxHold, mqAr, 5'd0, specNone, 6'd0, 9'h0, 36'h8_0000_1234, noRead);
    addRow(6'd4, arAdd, arxHold, mqHold, 5'd0, specXcryAr0, 6'd0, 9'h0, '0, diagArRead);
    addRow(6'd5, arHold, arxMagic, mqHold, 5'd0, specClrArr, 6'd0, 9'h0FF, '0, diagCrmRead);
    addRow(6'd6, arHold, arxHold, mqHold, nicondCode, specMqShift, 6'd0, 9'h0, '0, diagArRead);
    addRow(6'd7, arEbus, arxHold, mqZero, 5'd0, specNone, 6'd0, 9'h0, 36'h5_A5A5_A5A5, noRead);
    addRow(6'd8, arHold, arxHold, mqHold, 5'd0, specClrArl, 6'd0, 9'h0, '0, diagArRead);
    addRow(6'd9, arAdd, arxAr, mqHold, 5'd7, specXcryAr0, 6'h20, 9'h033, '0, diagCrmRead);
    addRow(6'd10, arArx, arxHold, mqAr, nicondCode, specNone, 6'h15, 9'h0, '0, diagArRead);
    repeat (3) @(posedge eboxClk);
    reset <= 1'b0;

    for (int i = 0; i < rowCount; i++) begin
      @(posedge eboxClk);
      diagStrobe <= 1'b1;
      diagFunc <= diagCrmWrite;
      diagAddr <= rows[i].addr;
      diagData <= rows[i].word;
      @(posedge eboxClk);
      diagStrobe <= 1'b0;
      diagData <= rows[i].ebusIn;
      uAddr <= rows[i].addr;
      uStep <= 1'b1;
      @(negedge eboxClk);
      checkState($sformatf("row %0d before", i), rows[i].arBefore, rows[i].arxBefore,
                 rows[i].mqBefore, prevNic);
      @(posedge eboxClk);
      uStep <= 1'b0;
      @(posedge eboxClk);  // Execute edge
      @(negedge eboxClk);
      prevNic = rows[i].word[27:23] == nicondCode;
      checkState($sformatf("row %0d after", i), rows[i].arAfter, rows[i].arxAfter,
                 rows[i].mqAfter, prevNic);
      if (rows[i].readFunc != noRead) begin
        issueRead(rows[i].readFunc, rows[i].addr,
                  rows[i].readFunc == diagArRead ? rows[i].arAfter : rows[i].word);
        @(posedge eboxClk);
        diagStrobe <= 1'b0;
        waitDrained();
      end
    end

    // Hold credits back until the arbiter runs dry
    while (owed != 0)
      @(negedge eboxClk);
    withhold = 1'b1;
    for (int k = 1; k <= creditDepth; k++) begin
      issueRead(diagCrmRead, 6'(k), rows[k-1].word);
      @(posedge eboxClk);
      diagStrobe <= 1'b0;
      waitDrained();
    end
    issueRead(diagCrmRead, 6'd5, rows[4].word);
    issueRead(diagArRead, 6'd0, mAr);
    @(posedge eboxClk);
    diagStrobe <= 1'b0;
    stalled = gotWords;
    repeat (8) @(posedge eboxClk);
    checks++;
    assert (gotWords == stalled) else begin
      errors++;
      $display("FAIL @%0t: EBUS word sent with no credit left", $time);
    end
    @(negedge eboxClk);
    withhold = 1'b0;
    waitDrained();

    issueRead(diagCrmRead, 6'd9, rows[8].word);
    issueRead(diagArRead, 6'd0, mAr);
    @(posedge eboxClk);
    diagStrobe <= 1'b0;
    waitDrained();
    repeat (4) @(posedge eboxClk);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* ebus/ebusArbiter.sv */
`timescale 1ns/1ps

module ebusArbiter #(
  parameter int ebusCredits = 4
) (
  input logic eboxClk,
  input logic reset,
  input logic reqCrm,
  input ebusPkg::ebusWordT dataCrm,
  input logic reqCtl,
  input ebusPkg::ebusWordT dataCtl,
  output logic gntCrm,
  output logic gntCtl,
  output logic ebusValid,
  output ebusPkg::ebusWordT ebusData,
  input logic ebusCreditReturn
);
  import ebusPkg::*;

  localparam int creditBits = $clog2(ebusCredits + 1);
  localparam int peerBits = $clog2(numPeers);

  logic [numPeers-1:0] req;
  logic [numPeers-1:0] gnt;
  logic [peerBits-1:0] lastWinner;
  logic [creditBits-1:0] creditCount;

  assign req[peerCrm] = reqCrm;
  assign req[peerCtl] = reqCtl;

  // Round robin where the last winner loses ties
  assign gnt[peerCrm] = (creditCount != '0) && req[peerCrm]
                        && (!req[peerCtl] || lastWinner == peerBits'(peerCtl));
  assign gnt[peerCtl] = (creditCount != '0) && req[peerCtl]
                        && (!req[peerCrm] || lastWinner == peerBits'(peerCrm));

  assign gntCrm = gnt[peerCrm];
  assign gntCtl = gnt[peerCtl];

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      ebusValid <= 1'b0;
      lastWinner <= peerBits'(peerCtl);  // Crm goes first
      creditCount <= creditBits'(ebusCredits);
    end else begin
      ebusValid <= |gnt;
      if (gnt[peerCrm]) lastWinner <= peerBits'(peerCrm);
      else if (gnt[peerCtl]) lastWinner <= peerBits'(peerCtl);
      creditCount <= creditCount - creditBits'(|gnt) + creditBits'(ebusCreditReturn);
    end
  end

  always_ff @(posedge eboxClk) begin
    if (|gnt)
      ebusData <= gnt[peerCtl] ? dataCtl : dataCrm;
  end

  // Consumer returns no more credits than words it was sent
  creditOverflow: assert property (
    @(posedge eboxClk) disable iff (reset)
      ebusCreditReturn |-> (creditCount < ebusCredits) || (|gnt)
  ) else $error("ebusArbiter: credit returned with counter already full");

  // A wrap below zero lands above the credit depth
  creditRange: assert property (
    @(posedge eboxClk) disable iff (reset) creditCount <= creditBits'(ebusCredits)
  ) else $error("ebusArbiter: credit counter out of range");

  grantOneHot: assert property (
    @(posedge eboxClk) disable iff (reset) $onehot0(gnt)
  ) else $error("ebusArbiter: more than one grant");

endmodule

/* sources.f */
common/cramPkg.sv
common/ebusPkg.sv
src/crm.sv
src/ctl.sv
src/edp.sv
ebus/ebusArbiter.sv
src/ebox.sv
dv/eboxTb.sv

/* src/crm.sv */
`timescale 1ns/1ps

module crm #(
  parameter int crmDepth = 64
) (
  input logic eboxClk,
  input logic reset,
  input logic [$clog2(crmDepth)-1:0] uAddr,
  input logic uStep,
  input logic diagStrobe,
  input logic [0:ebusPkg::diagFuncWidth-1] diagFunc,
  input logic [$clog2(crmDepth)-1:0] diagAddr,
  input ebusPkg::ebusWordT diagData,
  output cramPkg::microWordT cramWord,
  output logic wordFresh,
  output logic reqCrm,
  output ebusPkg::ebusWordT dataCrm,
  input logic gntCrm
);
  import cramPkg::*;
  import ebusPkg::*;

  logic [0:cramWidth-1] cram [crmDepth];
  logic diagWrite;
  logic diagRead;
  logic readAccept;

  assign diagWrite = diagStrobe && (diagFunc == diagCrmWrite);
  assign diagRead = diagStrobe && (diagFunc == diagCrmRead);
  assign readAccept = diagRead && !reqCrm;  // Dropped while one is pending

  always_ff @(posedge eboxClk) begin
    if (diagWrite)
      cram[diagAddr] <= diagData;
  end

  // Microword register
  always_ff @(posedge eboxClk) begin
    if (reset) begin
      cramWord <= '0;
      wordFresh <= 1'b0;
    end else begin
      wordFresh <= uStep;  // Marks the one execute cycle
      if (uStep)
        cramWord <= cram[uAddr];
    end
  end

  always_ff @(posedge eboxClk) begin
    if (reset)
      reqCrm <= 1'b0;
    else if (readAccept)
      reqCrm <= 1'b1;
    else if (gntCrm)
      reqCrm <= 1'b0;
  end

  // Read-back word held until granted
  always_ff @(posedge eboxClk) begin
    if (readAccept)
      dataCrm <= cram[diagAddr];
  end

  // A second read before the first one reached the EBUS would be lost
  crmReadOverrun: assert property (
    @(posedge eboxClk) disable iff (reset) diagRead |-> !reqCrm
  ) else $error("crm: CRAM read issued while previous read still pending");

endmodule

/* src/ctl.sv */
`timescale 1ns/1ps

module ctl (
  input logic eboxClk,
  input logic reset,
  input cramPkg::microWordT cramWord,
  input logic wordFresh,
  input ebusPkg::ebusWordT ar,
  input logic diagStrobe,
  input logic [0:ebusPkg::diagFuncWidth-1] diagFunc,
  input ebusPkg::ebusWordT diagData,
  output logic arLoadLeft,
  output logic arLoadRight,
  output logic arLeftClr,
  output logic arRightClr,
  output logic arxLoad,
  output logic mqLoad,
  output logic mqShift,
  output logic [0:cramPkg::arSelWidth-1] arSelect,
  output logic [0:cramPkg::arxSelWidth-1] arxSelect,
  output logic [0:cramPkg::mqSelWidth-1] mqSelect,
  output logic carry36,
  output ebusPkg::ebusWordT ebusDataIn,
  output logic dispNicond,
  output logic reqCtl,
  output ebusPkg::ebusWordT dataCtl,
  input logic gntCtl
);
  import cramPkg::*;
  import ebusPkg::*;

  logic specXcry;
  logic specClrL;
  logic specClrR;
  logic specShift;
  logic arLoad;
  logic arReadReq;

  always_comb begin
    specXcry = 1'b0;
    specClrL = 1'b0;
    specClrR = 1'b0;
    specShift = 1'b0;
    case (cramWord.spec)
      specNone: ;
      specXcryAr0: specXcry = 1'b1;
      specClrArl: specClrL = 1'b1;
      specClrArr: specClrR = 1'b1;
      specMqShift: specShift = 1'b1;
      default: ;  // Codes outside the kept set do nothing
    endcase
  end

  assign arSelect = cramWord.arSel;
  assign arxSelect = cramWord.arxSel;
  assign mqSelect = cramWord.mqSel;

  // Strobes only fire in the execute cycle
  assign arLoad = wordFresh && (cramWord.arSel != arHold);
  assign arLoadLeft = arLoad;
  assign arLoadRight = arLoad;
  assign arLeftClr = wordFresh && specClrL;
  assign arRightClr = wordFresh && specClrR;
  assign arxLoad = wordFresh && (cramWord.arxSel != arxHold);
  assign mqLoad = wordFresh && (cramWord.mqSel != mqHold);
  assign mqShift = wordFresh && specShift;

  assign carry36 = (ar[0] & specXcry) ^ cramWord.ad[0];
  assign dispNicond = cramWord.disp == cramPkg::dispNicond;

  assign ebusDataIn = diagData;  // AR source for arEbus

  assign arReadReq = diagStrobe && (diagFunc == diagArRead);

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      reqCtl <= 1'b0;
    end else if (arReadReq && !reqCtl) begin
      reqCtl <= 1'b1;
      dataCtl <= ar;
    end else if (gntCtl) begin
      reqCtl <= 1'b0;
    end
  end

  // Microcode must not load and clear the same half in one word
  arHalfConflict: assert property (
    @(posedge eboxClk) disable iff (reset)
      !((arLoadLeft && arLeftClr) || (arLoadRight && arRightClr))
  ) else $error("ctl: AR half loaded and cleared by the same microword");

  ctlReadOverrun: assert property (
    @(posedge eboxClk) disable iff (reset) arReadReq |-> !reqCtl
  ) else $error("ctl: AR read issued while previous read still pending");

endmodule

/* src/ebox.sv */
`timescale 1ns/1ps

module ebox #(
  parameter int crmDepth = 64,
  parameter int ebusCredits = 4
) (
  input logic eboxClk,
  input logic reset,
  input logic [$clog2(crmDepth)-1:0] uAddr,
  input logic uStep,
  input logic diagStrobe,
  input logic [0:ebusPkg::diagFuncWidth-1] diagFunc,
  input logic [$clog2(crmDepth)-1:0] diagAddr,
  input ebusPkg::ebusWordT diagData,
  output logic ebusValid,
  output ebusPkg::ebusWordT ebusData,
  input logic ebusCreditReturn,
  output ebusPkg::ebusWordT ar,
  output ebusPkg::ebusWordT arx,
  output ebusPkg::ebusWordT mq,
  output logic dispNicond
);
  import cramPkg::*;
  import ebusPkg::*;

  microWordT cramWord;
  logic wordFresh;
  logic arLoadLeft;
  logic arLoadRight;
  logic arLeftClr;
  logic arRightClr;
  logic arxLoad;
  logic mqLoad;
  logic mqShift;
  logic [0:arSelWidth-1] arSelect;
  logic [0:arxSelWidth-1] arxSelect;
  logic [0:mqSelWidth-1] mqSelect;
  logic carry36;
  ebusWordT ebusDataIn;
  logic reqCrm;
  logic reqCtl;
  logic gntCrm;
  logic gntCtl;
  ebusWordT dataCrm;
  ebusWordT dataCtl;

  crm #(.crmDepth(crmDepth)) u_crm (
    .eboxClk(eboxClk), .reset(reset),
    .uAddr(uAddr), .uStep(uStep),
    .diagStrobe(diagStrobe), .diagFunc(diagFunc), .diagAddr(diagAddr), .diagData(diagData),
    .cramWord(cramWord), .wordFresh(wordFresh),
    .reqCrm(reqCrm), .dataCrm(dataCrm), .gntCrm(gntCrm)
  );

  ctl u_ctl (
    .eboxClk(eboxClk), .reset(reset),
    .cramWord(cramWord), .wordFresh(wordFresh), .ar(ar),
    .diagStrobe(diagStrobe), .diagFunc(diagFunc), .diagData(diagData),
    .arLoadLeft(arLoadLeft), .arLoadRight(arLoadRight),
    .arLeftClr(arLeftClr), .arRightClr(arRightClr),
    .arxLoad(arxLoad), .mqLoad(mqLoad), .mqShift(mqShift),
    .arSelect(arSelect), .arxSelect(arxSelect), .mqSelect(mqSelect),
    .carry36(carry36), .ebusDataIn(ebusDataIn), .dispNicond(dispNicond),
    .reqCtl(reqCtl), .dataCtl(dataCtl), .gntCtl(gntCtl)
  );

  edp u_edp (
    .eboxClk(eboxClk), .reset(reset),
    .arLoadLeft(arLoadLeft), .arLoadRight(arLoadRight),
    .arLeftClr(arLeftClr), .arRightClr(arRightClr),
    .arxLoad(arxLoad), .mqLoad(mqLoad), .mqShift(mqShift),
    .arSelect(arSelect), .arxSelect(arxSelect), .mqSelect(mqSelect),
    .carry36(carry36), .magic(cramWord.magic), .ebusDataIn(ebusDataIn),
    .ar(ar), .arx(arx), .mq(mq)
  );

  ebusArbiter #(.ebusCredits(ebusCredits)) u_arb (
    .eboxClk(eboxClk), .reset(reset),
    .reqCrm(reqCrm), .dataCrm(dataCrm), .reqCtl(reqCtl), .dataCtl(dataCtl),
    .gntCrm(gntCrm), .gntCtl(gntCtl),
    .ebusValid(ebusValid), .ebusData(ebusData),
    .ebusCreditReturn(ebusCreditReturn)
  );

endmodule

/* src/edp.sv */
`timescale 1ns/1ps

module edp (
  input logic eboxClk,
  input logic reset,
  input logic arLoadLeft,
  input logic arLoadRight,
  input logic arLeftClr,
  input logic arRightClr,
  input logic arxLoad,
  input logic mqLoad,
  input logic mqShift,
  input logic [0:cramPkg::arSelWidth-1] arSelect,
  input logic [0:cramPkg::arxSelWidth-1] arxSelect,
  input logic [0:cramPkg::mqSelWidth-1] mqSelect,
  input logic carry36,
  input logic [0:cramPkg::magicWidth-1] magic,
  input ebusPkg::ebusWordT ebusDataIn,
  output ebusPkg::ebusWordT ar,
  output ebusPkg::ebusWordT arx,
  output ebusPkg::ebusWordT mq
);
  import cramPkg::*;
  import ebusPkg::*;

  ebusWordT adSum;
  ebusWordT magicExt;
  ebusWordT arNext;
  ebusWordT arxNext;
  ebusWordT mqNext;

  assign magicExt = ebusWidth'(magic);
  assign adSum = ar + arx + ebusWidth'(carry36);  // Wraps at 36 bits

  always_comb begin
    case (arSelect)
      arHold: arNext = ar;
      arMagic: arNext = magicExt;
      arArx: arNext = arx;
      arAdd: arNext = adSum;
      arEbus: arNext = ebusDataIn;
      default: arNext = ar;
    endcase
  end

  always_comb begin
    case (arxSelect)
      arxHold: arxNext = arx;
      arxAr: arxNext = ar;
      arxMq: arxNext = mq;
      arxMagic: arxNext = magicExt;
      default: arxNext = arx;
    endcase
  end

  always_comb begin
    case (mqSelect)
      mqHold: mqNext = mq;
      mqAr: mqNext = ar;
      mqZero: mqNext = '0;
      default: mqNext = mq;
    endcase
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      ar <= '0;
      arx <= '0;
      mq <= '0;
    end else begin
      // Clear beats load per half
      if (arLeftClr) ar[0:17] <= '0;
      else if (arLoadLeft) ar[0:17] <= arNext[0:17];
      if (arRightClr) ar[18:35] <= '0;
      else if (arLoadRight) ar[18:35] <= arNext[18:35];
      if (arxLoad)
        arx <= arxNext;
      if (mqShift)
        mq <= {mq[1:35], ar[0]};  // AR0 into the vacated low bit
      else if (mqLoad)
        mq <= mqNext;
    end
  end

endmodule
